// ==== design/rv_pkg.sv ====
// rv64 integer core shared definitions
// widths, opcodes, alu function codes and reset values
`default_nettype none

package rv_pkg;

    // data and instruction widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [ILEN-1:0]      inst_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]      pc_t;
    typedef logic [2:0]           funct3_t;

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111
    } opcode_t;

    // alu function codes, taken from funct3
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    localparam pc_t RESET_PC = 64'h0000_0000_8000_0000;

    // every strobed word is a full 32-bit instruction
    localparam int INST_BYTES = 4;

endpackage

`default_nettype wire

// ==== design/rv_if.sv ====
// pipeline stage interfaces
// decode to execute bundle and the writeback result
`timescale 1ns/10ps
`default_nettype none

interface id_ex_if
    import rv_pkg::*;
();
    inst_t ir;
    pc_t   pc;
    xlen_t rs1_data;
    xlen_t rs2_data;
    xlen_t imm;
    logic  valid;

    modport decode_mp  (output ir, pc, rs1_data, rs2_data, imm, valid);
    modport execute_mp (input  ir, pc, rs1_data, rs2_data, imm, valid);
endinterface

interface wb_if
    import rv_pkg::*;
();
    logic     valid;
    logic     we;
    reg_idx_t rd;
    xlen_t    data;
    pc_t      pc;

    modport source_mp (output valid, we, rd, data, pc);
    modport sink_mp   (input  valid, we, rd, data, pc);
endinterface

`default_nettype wire

// ==== design/rv_regfile.sv ====
// integer register file with x0 hard-wired to zero
// two read ports with write-through of the result being written
`timescale 1ns/10ps
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  wire      c_clk,
    input  wire      c_rst_n,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o,
    input  wire      we_i,
    input  reg_idx_t rd_i,
    input  xlen_t    rd_data_i
);

    xlen_t regs [31:1];

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    function automatic xlen_t read_port(input reg_idx_t idx);
        xlen_t val;
        if (idx == '0) begin
            val = '0;
        end else if (we_i && idx == rd_i) begin
            // same-cycle write wins
            val = rd_data_i;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

// ==== design/rv_alu.sv ====
// 64-bit integer alu with the 32-bit word forms
// word results are sign-extended from bit 31
`timescale 1ns/10ps
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  xlen_t   a_i,
    input  xlen_t   b_i,
    input  opcode_t opcode_i,
    input  funct3_t funct3_i,
    input  wire     alt_i,
    output xlen_t   result_o
);

    logic        is_word;
    logic        sub_en;
    logic        force_add;
    xlen_t       sum_res;
    xlen_t       sll_res;
    xlen_t       srl_res;
    xlen_t       sra_res;
    xlen_t       full_res;
    logic [31:0] word_sll;
    logic [31:0] word_srl;
    logic [31:0] word_sra;
    logic [31:0] word_res;

    always_comb begin
        is_word   = opcode_i inside {OP_32, OP_IMM_32};
        // immediates carry bit 30 as data, so only register forms subtract
        sub_en    = alt_i && (opcode_i inside {OP, OP_32});
        force_add = opcode_i inside {LUI, AUIPC};

        sum_res = sub_en ? a_i - b_i : a_i + b_i;
        sll_res = a_i << b_i[5:0];
        srl_res = a_i >> b_i[5:0];
        sra_res = $signed(a_i) >>> b_i[5:0];

        word_sll = a_i[31:0] << b_i[4:0];
        word_srl = a_i[31:0] >> b_i[4:0];
        word_sra = $signed(a_i[31:0]) >>> b_i[4:0];

        case (funct3_i)
            F3_ADD:  full_res = sum_res;
            F3_SLL:  full_res = sll_res;
            F3_SLT:  full_res = {63'b0, $signed(a_i) < $signed(b_i)};
            F3_SLTU: full_res = {63'b0, a_i < b_i};
            F3_XOR:  full_res = a_i ^ b_i;
            F3_SR:   full_res = alt_i ? sra_res : srl_res;
            F3_OR:   full_res = a_i | b_i;
            default: full_res = a_i & b_i;
        endcase

        // word add and the other codes take the low half of the full result
        case (funct3_i)
            F3_SLL:  word_res = word_sll;
            F3_SR:   word_res = alt_i ? word_sra : word_srl;
            default: word_res = full_res[31:0];
        endcase

        if (force_add) begin
            result_o = sum_res;
        end else if (is_word) begin
            result_o = {{32{word_res[31]}}, word_res};
        end else begin
            result_o = full_res;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_decode.sv ====
// decode stage with the program counter, decode register, register read
// and immediate formatting into the id_ex bundle
`timescale 1ns/10ps
`default_nettype none

module rv_decode
    import rv_pkg::*;
(
    input  wire              c_clk,
    input  wire              c_rst_n,
    input  wire              ins_valid_i,
    input  inst_t            ins_i,
    id_ex_if.decode_mp       id_ex,
    wb_if.sink_mp            wb
);

    pc_t   pc;
    pc_t   dec_pc;
    inst_t dec_ir;
    logic  dec_valid;

    xlen_t rs1_data;
    xlen_t rs2_data;
    xlen_t imm_fmt;
    logic  op_kept;

    // tag each strobed word with its address
    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            pc        <= RESET_PC;
            dec_valid <= 1'b0;
            dec_ir    <= NOP_INST;
        end else begin
            dec_valid <= ins_valid_i;
            if (ins_valid_i) begin
                dec_ir <= ins_i;
                pc     <= pc + pc_t'(INST_BYTES);
            end
        end
    end

    always_ff @(posedge c_clk) begin
        if (ins_valid_i) begin
            dec_pc <= pc;
        end
    end

    rv_regfile u_regfile (
        .c_clk      (c_clk),
        .c_rst_n    (c_rst_n),
        .rs1_i      (dec_ir[19:15]),
        .rs2_i      (dec_ir[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb.valid && wb.we),
        .rd_i       (wb.rd),
        .rd_data_i  (wb.data)
    );

    // immediate format and opcode filter
    always_comb begin
        imm_fmt = '0;
        op_kept = 1'b1;
        case (dec_ir[6:0])
            OP_IMM, OP_IMM_32: begin
                imm_fmt = {{52{dec_ir[31]}}, dec_ir[31:20]};
            end
            LUI, AUIPC: begin
                imm_fmt = {{32{dec_ir[31]}}, dec_ir[31:12], 12'b0};
            end
            OP, OP_32: begin
                imm_fmt = '0;
            end
            default: begin
                op_kept = 1'b0;
            end
        endcase
    end

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            // unsupported opcodes become bubbles here
            id_ex.valid <= dec_valid && op_kept;
        end
    end

    always_ff @(posedge c_clk) begin
        id_ex.ir       <= dec_ir;
        id_ex.pc       <= dec_pc;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm_fmt;
    end

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
// execute stage with operand forwarding, alu and the writeback register
`timescale 1ns/10ps
`default_nettype none

module rv_execute
    import rv_pkg::*;
(
    input  wire          c_clk,
    input  wire          c_rst_n,
    id_ex_if.execute_mp  id_ex,
    wb_if.source_mp      wb
);

    opcode_t  opcode;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     fwd_rs1;
    logic     fwd_rs2;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    op_a;
    xlen_t    op_b;
    xlen_t    alu_res;

    always_comb begin
        opcode = opcode_t'(id_ex.ir[6:0]);
        rs1    = id_ex.ir[19:15];
        rs2    = id_ex.ir[24:20];
        rd     = id_ex.ir[11:7];

        // we already implies a nonzero rd
        fwd_rs1 = wb.valid && wb.we && (wb.rd == rs1);
        fwd_rs2 = wb.valid && wb.we && (wb.rd == rs2);
        rs1_val = fwd_rs1 ? wb.data : id_ex.rs1_data;
        rs2_val = fwd_rs2 ? wb.data : id_ex.rs2_data;

        case (opcode)
            LUI:     op_a = '0;
            AUIPC:   op_a = id_ex.pc;
            default: op_a = rs1_val;
        endcase

        if (opcode inside {OP, OP_32}) begin
            op_b = rs2_val;
        end else begin
            op_b = id_ex.imm;
        end
    end

    rv_alu u_alu (
        .a_i      (op_a),
        .b_i      (op_b),
        .opcode_i (opcode),
        .funct3_i (id_ex.ir[14:12]),
        .alt_i    (id_ex.ir[30]),
        .result_o (alu_res)
    );

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            wb.valid <= 1'b0;
            wb.we    <= 1'b0;
        end else begin
            wb.valid <= id_ex.valid;
            wb.we    <= id_ex.valid && (rd != '0);
        end
    end

    always_ff @(posedge c_clk) begin
        wb.rd   <= rd;
        wb.data <= alu_res;
        wb.pc   <= id_ex.pc;
    end

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
// rv64 integer core as a three-stage in-order pipeline
// one instruction per input strobe, retire reported two cycles later
`timescale 1ns/10ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  wire      c_clk,
    input  wire      c_rst_n,
    input  wire      ins_valid_i,
    input  inst_t    ins_i,
    output logic     retire_valid_o,
    output pc_t      retire_pc_o,
    output reg_idx_t retire_rd_o,
    output xlen_t    retire_data_o
);

    id_ex_if id_ex ();
    wb_if    wb ();

    rv_decode u_decode (
        .c_clk       (c_clk),
        .c_rst_n     (c_rst_n),
        .ins_valid_i (ins_valid_i),
        .ins_i       (ins_i),
        .id_ex       (id_ex.decode_mp),
        .wb          (wb.sink_mp)
    );

    rv_execute u_execute (
        .c_clk   (c_clk),
        .c_rst_n (c_rst_n),
        .id_ex   (id_ex.execute_mp),
        .wb      (wb.source_mp)
    );

    // retire port is the writeback register itself
    assign retire_valid_o = wb.valid;
    assign retire_pc_o    = wb.pc;
    assign retire_rd_o    = wb.rd;
    assign retire_data_o  = wb.data;

endmodule

`default_nettype wire

// ==== tests/rv_core_checker.sv ====
// retire checker for the rv64 core
// pairs each retire with the oldest model expectation and keeps per-test counts
`timescale 1ns/10ps
`default_nettype none

module rv_core_checker
    import rv_pkg::*;
(
    input  wire        c_clk,
    input  wire        retire_valid_i,
    input  pc_t        retire_pc_i,
    input  reg_idx_t   retire_rd_i,
    input  xlen_t      retire_data_i,
    input  wire        exp_valid_i,
    input  pc_t        exp_pc_i,
    input  reg_idx_t   exp_rd_i,
    input  xlen_t      exp_data_i,
    input  wire [2:0]  test_id_i,
    input  wire        report_i,
    output int         pending_o,
    output int         checks_o,
    output int         errors_o
);

    typedef struct packed {
        pc_t      pc;
        reg_idx_t rd;
        xlen_t    data;
    } exp_t;

    exp_t exp_q [$];
    exp_t exp_in;
    exp_t exp_head;
    int   test_checks;
    int   test_errors;

    function automatic string test_name(input logic [2:0] id);
        string s;
        case (id)
            3'd0:    s = "alu_random";
            3'd1:    s = "word_forms";
            3'd2:    s = "forwarding";
            3'd3:    s = "upper_imm";
            default: s = "x0_and_bubbles";
        endcase
        return s;
    endfunction

    task automatic compare(input string field, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %h, actual %h",
                     test_name(test_id_i), field, exp, act);
            errors_o++;
            test_errors++;
        end
    endtask

    always @(posedge c_clk) begin
        if (exp_valid_i) begin
            exp_in.pc   = exp_pc_i;
            exp_in.rd   = exp_rd_i;
            exp_in.data = exp_data_i;
            exp_q.push_back(exp_in);
        end
        if (retire_valid_i) begin
            if (exp_q.size() == 0) begin
                $display("error: in test %s a retire at pc %h arrived with nothing expected",
                         test_name(test_id_i), retire_pc_i);
                errors_o++;
                test_errors++;
            end else begin
                exp_head = exp_q.pop_front();
                compare("pc", exp_head.pc, retire_pc_i);
                compare("rd", xlen_t'(exp_head.rd), xlen_t'(retire_rd_i));
                compare("data", exp_head.data, retire_data_i);
                checks_o++;
                test_checks++;
            end
        end
        if (report_i) begin
            $display("test %s done: %0d retired, %0d errors",
                     test_name(test_id_i), test_checks, test_errors);
            // next test starts with an empty queue
            exp_q.delete();
            test_checks = 0;
            test_errors = 0;
        end
        pending_o = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== tests/rv_core_sva.sv ====
// protocol assertions for the rv64 core retire port
`timescale 1ns/10ps
`default_nettype none

module rv_core_sva
    import rv_pkg::*;
(
    input wire      c_clk,
    input wire      c_rst_n,
    input wire      ins_valid_i,
    input wire      retire_valid_i,
    input reg_idx_t retire_rd_i,
    input wire      wb_we_i
);

    quiet_after_reset: assert property (
        @(posedge c_clk) (!c_rst_n || $rose(c_rst_n)) |-> !retire_valid_i
    ) else $error("retire_valid_o high during or right after reset");

    // three edges back is the edge where decode took the strobe
    retire_follows_strobe: assert property (
        @(posedge c_clk) disable iff (!c_rst_n)
        retire_valid_i |-> $past(ins_valid_i, 3)
    ) else $error("retire without an input strobe two cycles earlier");

    write_has_rd: assert property (
        @(posedge c_clk) disable iff (!c_rst_n)
        (retire_valid_i && wb_we_i) |-> (retire_rd_i != '0)
    ) else $error("retired write enabled with rd zero");

endmodule

bind rv_core rv_core_sva u_sva (
    .c_clk          (c_clk),
    .c_rst_n        (c_rst_n),
    .ins_valid_i    (ins_valid_i),
    .retire_valid_i (retire_valid_o),
    .retire_rd_i    (retire_rd_o),
    .wb_we_i        (wb.we)
);

`default_nettype wire

// ==== tests/tb_rv_core.sv ====
// testbench for the rv64 integer core
// random and directed instruction streams checked against a register model
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    logic        c_clk;
    logic        c_rst_n;
    logic        ins_valid;
    inst_t       ins_word;
    logic        retire_valid;
    pc_t         retire_pc;
    reg_idx_t    retire_rd;
    xlen_t       retire_data;

    logic        exp_valid;
    pc_t         exp_pc;
    reg_idx_t    exp_rd;
    xlen_t       exp_data;
    logic [2:0]  test_id;
    logic        report;
    int          pending;
    int          checks;
    int          errors;
    int          timeouts;

    xlen_t       model_regs [32];
    pc_t         model_pc;
    logic [31:0] rnd;
    inst_t       ins_tmp;
    int          i;

    always #10 c_clk = ~c_clk;

    rv_core rv_core_inst (
        .c_clk          (c_clk),
        .c_rst_n        (c_rst_n),
        .ins_valid_i    (ins_valid),
        .ins_i          (ins_word),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data)
    );

    rv_core_checker u_checker (
        .c_clk          (c_clk),
        .retire_valid_i (retire_valid),
        .retire_pc_i    (retire_pc),
        .retire_rd_i    (retire_rd),
        .retire_data_i  (retire_data),
        .exp_valid_i    (exp_valid),
        .exp_pc_i       (exp_pc),
        .exp_rd_i       (exp_rd),
        .exp_data_i     (exp_data),
        .test_id_i      (test_id),
        .report_i       (report),
        .pending_o      (pending),
        .checks_o       (checks),
        .errors_o       (errors)
    );

    // architectural result of one instruction on the model state
    function automatic xlen_t model_result(input inst_t ins, input pc_t pc);
        xlen_t       a;
        xlen_t       b;
        xlen_t       r;
        logic [31:0] w;
        logic        reg_form;
        reg_form = (ins[6:0] == OP) || (ins[6:0] == OP_32);
        a = model_regs[ins[19:15]];
        b = reg_form ? model_regs[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
        w = '0;
        case (ins[6:0])
            LUI:   r = {{32{ins[31]}}, ins[31:12], 12'h000};
            AUIPC: r = pc + {{32{ins[31]}}, ins[31:12], 12'h000};
            OP, OP_IMM: begin
                case (ins[14:12])
                    3'd0:    r = (reg_form && ins[30]) ? a - b : a + b;
                    3'd1:    r = a << b[5:0];
                    3'd2:    r = xlen_t'($signed(a) < $signed(b));
                    3'd3:    r = xlen_t'(a < b);
                    3'd4:    r = a ^ b;
                    3'd5:    r = ins[30] ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
                    3'd6:    r = a | b;
                    default: r = a & b;
                endcase
            end
            default: begin
                case (ins[14:12])
                    3'd0:    w = (reg_form && ins[30]) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                    3'd1:    w = a[31:0] << b[4:0];
                    default: w = ins[30] ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
                endcase
                r = {{32{w[31]}}, w};
            end
        endcase
        return r;
    endfunction

    function automatic inst_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_r(input logic [6:0] opc, input logic [6:0] f7,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input reg_idx_t rs1, input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    // legal alu encoding with register indexes limited by mask
    function automatic inst_t gen_alu(input logic word, input reg_idx_t mask);
        inst_t       ins;
        logic [31:0] r;
        ins = $urandom;
        r = $urandom;
        if (word && !(ins[14:12] inside {3'd0, 3'd1, 3'd5})) begin
            ins[14:12] = 3'd0;
        end
        ins[11:7] = ins[11:7] & mask;
        ins[19:15] = ins[19:15] & mask;
        if (r[0]) begin
            ins[24:20] = ins[24:20] & mask;
            ins[31:25] = (ins[14:12] inside {3'd0, 3'd5}) ? {1'b0, r[1], 5'b0} : 7'b0;
            ins[6:0] = word ? OP_32 : OP;
        end else begin
            if (ins[14:12] inside {3'd1, 3'd5}) begin
                ins[31:26] = {1'b0, r[1], 4'b0};
                ins[25] = ins[25] & ~word;
            end
            ins[6:0] = word ? OP_IMM_32 : OP_IMM;
        end
        return ins;
    endfunction

    function automatic inst_t gen_upper(input reg_idx_t mask);
        inst_t ins;
        ins = $urandom;
        ins[11:7] = ins[11:7] & mask;
        ins[6:0] = ins[12] ? LUI : AUIPC;
        return ins;
    endfunction

    function automatic inst_t gen_unsup();
        inst_t ins;
        ins = $urandom;
        ins[1:0] = 2'b11;
        if (ins[6:0] inside {OP, OP_IMM, OP_32, OP_IMM_32, LUI, AUIPC}) begin
            ins[6:0] = 7'b1100011;
        end
        return ins;
    endfunction

    task automatic send(input inst_t ins);
        logic  kept;
        xlen_t res;
        @(negedge c_clk);
        kept = ins[6:0] inside {OP, OP_IMM, OP_32, OP_IMM_32, LUI, AUIPC};
        res = model_result(ins, model_pc);
        ins_valid = 1'b1;
        ins_word = ins;
        exp_valid = kept;
        exp_pc = model_pc;
        exp_rd = ins[11:7];
        exp_data = res;
        if (kept && ins[11:7] != 5'd0) begin
            model_regs[ins[11:7]] = res;
        end
        model_pc = model_pc + pc_t'(INST_BYTES);
    endtask

    task automatic idle_cycle();
        @(negedge c_clk);
        ins_valid = 1'b0;
        exp_valid = 1'b0;
    endtask

    task automatic finish_test();
        int n;
        idle_cycle();
        n = 0;
        while (pending != 0 && n < 20) begin
            @(negedge c_clk);
            n++;
        end
        if (pending != 0) begin
            $display("error: %0d expected retires never arrived in test %0d", pending, test_id);
            timeouts++;
        end
        @(negedge c_clk);
        report = 1'b1;
        @(negedge c_clk);
        report = 1'b0;
    endtask

    initial begin
        c_clk = 1'b0;
        c_rst_n = 1'b0;
        ins_valid = 1'b0;
        ins_word = NOP_INST;
        exp_valid = 1'b0;
        exp_pc = '0;
        exp_rd = '0;
        exp_data = '0;
        test_id = 3'd0;
        report = 1'b0;
        timeouts = 0;
        model_pc = RESET_PC;
        for (i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        rnd = $urandom(32'hf951);
        repeat (3) @(negedge c_clk);
        c_rst_n = 1'b1;

        test_id = 3'd0;
        for (i = 0; i < 200; i++) begin
            rnd = $urandom;
            if (rnd[0]) begin
                idle_cycle();
            end
            if (rnd[3:1] == 3'd0) begin
                send(gen_upper(5'h07));
            end else begin
                send(gen_alu(1'b0, 5'h07));
            end
        end
        finish_test();

        // large upper values exercise sign extension of word results
        test_id = 3'd1;
        for (i = 0; i < 150; i++) begin
            rnd = $urandom;
            if (rnd[2:0] == 3'd0) begin
                send(gen_upper(5'h07));
            end else begin
                send(gen_alu(1'b1, 5'h07));
            end
        end
        finish_test();

        // x1 consumed at distance 1, 2 and 3
        test_id = 3'd2;
        send(enc_i(OP_IMM, 3'd0, 5'd1, 5'd0, 12'h7f3));
        send(enc_i(OP_IMM, 3'd0, 5'd2, 5'd1, 12'h005));
        send(enc_r(OP, 7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
        send(enc_r(OP, 7'h20, 3'd0, 5'd4, 5'd1, 5'd3));
        send(enc_r(OP_32, 7'h00, 3'd1, 5'd5, 5'd4, 5'd4));
        for (i = 0; i < 150; i++) begin
            rnd = $urandom;
            send(gen_alu(rnd[0], 5'h03));
        end
        finish_test();

        test_id = 3'd3;
        for (i = 0; i < 80; i++) begin
            rnd = $urandom;
            case (rnd[1:0])
                2'd0:    send(gen_unsup());
                2'd1:    send(enc_i(OP_IMM, 3'd0, 5'd2, 5'd1, 12'h001));
                default: send(gen_upper(5'h01));
            endcase
        end
        finish_test();

        test_id = 3'd4;
        send(enc_i(OP_IMM, 3'd0, 5'd0, 5'd0, 12'h5a5));
        send(enc_r(OP, 7'h00, 3'd0, 5'd6, 5'd0, 5'd0));
        send(enc_i(OP_IMM, 3'd6, 5'd7, 5'd0, 12'h001));
        for (i = 0; i < 60; i++) begin
            rnd = $urandom;
            if (rnd[0]) begin
                send(gen_unsup());
            end else begin
                ins_tmp = gen_alu(rnd[1], 5'h07);
                ins_tmp[11:7] = 5'd0;
                send(ins_tmp);
            end
        end
        finish_test();

        $display("summary: %0d retired, %0d errors, %0d drain timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/rv_pkg.sv
design/rv_if.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_core.sv
tests/rv_core_checker.sv
tests/rv_core_sva.sv
tests/tb_rv_core.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_rv_core
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
